/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary -j 0 -Wno-fatal
TOP       = softmax_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = SIMULATION FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails when the log holds the fail message or the binary exits with an error.
run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/softmax_model.svh */
`ifndef SOFTMAX_MODEL_SVH
`define SOFTMAX_MODEL_SVH

`default_nettype none

// Difference in the log domain, optionally times log2(e), kept within [-16, 0].
function automatic logic [15:0] model_exp_diff(input logic [15:0] minuend,
                                               input logic [15:0] subtrahend,
                                               input bit          scale);
    longint d;
    d = longint'($signed(minuend)) - longint'($signed(subtrahend));
    if (scale) begin
        // Arithmetic shift rounds toward minus infinity.
        d = (d * longint'(softmax_pkg::log2e_q)) >>> softmax_pkg::frac_w;
    end
    if (d > 0) begin
        d = 0;
    end
    if (d < longint'(softmax_pkg::min_exp)) begin
        d = longint'(softmax_pkg::min_exp);
    end
    return d[15:0];
endfunction

// Two to the power x, linear mantissa, Q1.15 result.
function automatic logic [15:0] model_pow2(input logic [15:0] x);
    int k;
    int f;
    int mant;
    k    = int'($signed(x)) >>> softmax_pkg::frac_w;
    f    = int'(x[7:0]);
    mant = 32'h8000 + f * 128;
    return 16'(mant >> (-k));
endfunction

// Base-2 log of a Q1.15 sum, as signed Q8.8.
function automatic logic [15:0] model_log2(input logic [softmax_pkg::sum_w-1:0] sum);
    int p;
    int m;
    int lg;
    p = 0;
    for (int b = 0; b < softmax_pkg::sum_w; b++) begin
        if (sum[b]) begin
            p = b;
        end
    end
    m  = int'((longint'(sum) << 8) >> p) & 255;
    lg = (p - softmax_pkg::prob_frac_w) * 256 + m;
    return lg[15:0];
endfunction

// Whole softmax over one flat vector of scores.
function automatic logic [127:0] model_softmax(input logic [127:0] scores);
    logic [15:0]                    mx;
    logic [15:0]                    ex [softmax_pkg::vec_len];
    logic [softmax_pkg::sum_w-1:0]  sum;
    logic [15:0]                    lg;
    logic [127:0]                   probs;
    mx = scores[15:0];
    for (int i = 1; i < softmax_pkg::vec_len; i++) begin
        if ($signed(scores[i*16 +: 16]) > $signed(mx)) begin
            mx = scores[i*16 +: 16];
        end
    end
    sum = '0;
    for (int i = 0; i < softmax_pkg::vec_len; i++) begin
        ex[i] = model_exp_diff(scores[i*16 +: 16], mx, 1'b1);
        sum   = sum + softmax_pkg::sum_w'(model_pow2(ex[i]));
    end
    lg = model_log2(sum);
    for (int i = 0; i < softmax_pkg::vec_len; i++) begin
        probs[i*16 +: 16] = model_pow2(model_exp_diff(ex[i], lg, 1'b0));
    end
    return probs;
endfunction

`default_nettype wire

`endif

/* dv/softmax_tb.sv */
`include "softmax_model.svh"

`default_nettype none

module softmax_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_fixed     = 4;
    localparam int n_rand      = 12;
    localparam int n_stall     = 12;
    localparam int n_entries   = n_fixed + n_rand + n_stall;
    localparam int flat_w      = softmax_pkg::vec_len * softmax_pkg::data_w;
    localparam int watchdog_ns = (n_entries * (softmax_pkg::total_lat + 8) + 100) * 8;

    // Enabled cycles from valid_in to valid_out.
    localparam int pipe_lat    = 11;

    logic              clk;
    logic              rst_n;
    logic              en;
    logic              valid_in;
    logic [flat_w-1:0] scores_flat;
    logic [flat_w-1:0] prob_flat;
    logic              valid_out;

    // Stimulus table.
    // tbl_en holds en for successive cycles, LSB first. The first 1 accepts the vector.
    logic [flat_w-1:0] tbl_scores [n_entries];
    logic [3:0]        tbl_en     [n_entries];
    logic [flat_w-1:0] tbl_exp    [n_entries];
    string             tbl_name   [n_entries];

    // Scoreboard state.
    int   idx_q [$];
    int   acc_q [$];
    int   cur_idx;
    int   en_cnt;
    int   n_done;
    int   err_cnt;
    int   pass_cnt;
    int   fail_cnt;
    logic prev_en;
    logic prev_valid;

    softmax i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .valid_in    (valid_in),
        .scores_flat (scores_flat),
        .prob_flat   (prob_flat),
        .valid_out   (valid_out)
    );

    always #4 clk = ~clk;

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%04h, expected 0x%04h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail", name);
        end
    endtask

    task automatic build_table();
        logic [31:0]       r;
        logic [flat_w-1:0] sc;
        int                e;
        // Equal scores give 2^-3 everywhere.
        tbl_name[0]   = "equal_0123";
        tbl_scores[0] = {8{16'h0123}};
        tbl_exp[0]    = {8{16'h1000}};
        tbl_en[0]     = 4'b0001;
        tbl_name[1]   = "equal_min";
        tbl_scores[1] = {8{16'h8000}};
        tbl_exp[1]    = {8{16'h1000}};
        tbl_en[1]     = 4'b0001;
        // One score at +8.0, the others at -8.0.
        tbl_name[2]   = "dominant_3";
        tbl_scores[2] = {{4{16'hf800}}, 16'h0800, {3{16'hf800}}};
        tbl_exp[2]    = {{4{16'h0000}}, 16'h8000, {3{16'h0000}}};
        tbl_en[2]     = 4'b0001;
        tbl_name[3]   = "dominant_0";
        tbl_scores[3] = {{7{16'hf800}}, 16'h0800};
        tbl_exp[3]    = {{7{16'h0000}}, 16'h8000};
        tbl_en[3]     = 4'b0001;
        for (int k = 0; k < n_rand + n_stall; k++) begin
            e = n_fixed + k;
            for (int j = 0; j < softmax_pkg::vec_len; j++) begin
                r = $urandom;
                // Mostly within +-4.0 so that few terms clamp.
                if (k % 3 == 2) begin
                    sc[j*16 +: 16] = r[15:0];
                end else begin
                    sc[j*16 +: 16] = {{5{r[10]}}, r[10:0]};
                end
            end
            tbl_scores[e] = sc;
            tbl_exp[e]    = model_softmax(sc);
            if (k < n_rand) begin
                tbl_name[e] = $sformatf("random_%0d", k);
                tbl_en[e]   = 4'b0001;
            end else begin
                tbl_name[e] = $sformatf("stall_%0d", k - n_rand);
                tbl_en[e]   = {1'b1, r[18:16]};
            end
        end
    endtask

    task automatic check_output();
        int idx;
        int lat;
        int errs_before;
        if (idx_q.size() == 0) begin
            $display("ERROR: valid_out rose with no vector pending at %0t", $time);
            err_cnt++;
        end else begin
            idx         = idx_q.pop_front();
            lat         = en_cnt - acc_q.pop_front();
            errs_before = err_cnt;
            check_val("valid_out latency", 16'(lat), 16'(pipe_lat));
            for (int i = 0; i < softmax_pkg::vec_len; i++) begin
                check_val($sformatf("prob_flat[%0d]", i),
                          prob_flat[i*softmax_pkg::data_w +: softmax_pkg::data_w],
                          tbl_exp[idx][i*softmax_pkg::data_w +: softmax_pkg::data_w]);
            end
            report_test(tbl_name[idx], errs_before);
            n_done++;
        end
    endtask

    // Transfers happen on rising edges with en high.
    always @(posedge clk) begin
        if (rst_n) begin
            if (!prev_en && valid_out !== prev_valid) begin
                $display("ERROR: valid_out changed while en was low at %0t", $time);
                err_cnt++;
            end
            if (en) begin
                if (valid_out) begin
                    check_output();
                end
                if (valid_in) begin
                    idx_q.push_back(cur_idx);
                    acc_q.push_back(en_cnt);
                end
                en_cnt++;
            end
        end
        prev_en    = en;
        prev_valid = valid_out;
    end

    initial begin
        logic accepted;
        int   errs_before;
        clk         = 1'b0;
        rst_n       = 1'b0;
        en          = 1'b1;
        valid_in    = 1'b0;
        scores_flat = '0;
        cur_idx     = 0;
        en_cnt      = 0;
        n_done      = 0;
        err_cnt     = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        prev_en     = 1'b1;
        prev_valid  = 1'b0;
        void'($urandom(32'hf023));
        build_table();

        errs_before = err_cnt;
        repeat (3) begin
            @(negedge clk);
            check_val("valid_out", 16'(valid_out), 16'h0000);
        end
        rst_n = 1'b1;
        repeat (softmax_pkg::total_lat + 2) begin
            @(negedge clk);
            check_val("valid_out", 16'(valid_out), 16'h0000);
        end
        report_test("reset", errs_before);

        for (int e = 0; e < n_entries; e++) begin
            cur_idx     = e;
            scores_flat = tbl_scores[e];
            valid_in    = 1'b1;
            accepted    = 1'b0;
            for (int b = 0; b < 4 && !accepted; b++) begin
                en       = tbl_en[e][b];
                accepted = tbl_en[e][b];
                @(negedge clk);
            end
        end
        valid_in = 1'b0;
        en       = 1'b1;
        wait (n_done == n_entries);
        // Quiet period to catch duplicated outputs.
        repeat (softmax_pkg::total_lat + 4) @(negedge clk);

        $display("tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("ERROR: run timed out after %0d ns with %0d of %0d vectors checked",
                 watchdog_ns, n_done, n_entries);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+dv
verilog/softmax_pkg.sv
verilog/max_tree.sv
verilog/exp2_unit.sv
verilog/log_sum_tree.sv
verilog/softmax.sv
dv/softmax_tb.sv

/* verilog/exp2_unit.sv */
`default_nettype none

module exp2_unit #(
    parameter bit scale_log2e = 1'b1
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                en,
    input  wire                                valid_in,
    input  wire  [softmax_pkg::data_w-1:0]     minuend,
    input  wire  [softmax_pkg::data_w-1:0]     subtrahend,
    output logic [softmax_pkg::data_w-1:0]     expo,
    output logic [softmax_pkg::data_w-1:0]     pow,
    output logic                               valid_out
);

    // Stage 1 signals.
    logic signed [softmax_pkg::data_w:0]     diff;
    logic signed [2*softmax_pkg::data_w+1:0] diff_w;
    logic signed [2*softmax_pkg::data_w+1:0] prod;
    logic signed [2*softmax_pkg::data_w+1:0] scaled;
    softmax_pkg::log_word_u                  clamped;
    softmax_pkg::log_word_u                  expo_q;
    logic                                    valid_q;

    // Stage 2 signals.
    logic [softmax_pkg::data_w-1:0]                    mant;
    logic [softmax_pkg::data_w-softmax_pkg::frac_w-1:0] shamt;

    always_comb begin
        diff = $signed({minuend[softmax_pkg::data_w-1], minuend})
             - $signed({subtrahend[softmax_pkg::data_w-1], subtrahend});
        diff_w = {{(softmax_pkg::data_w+1){diff[softmax_pkg::data_w]}}, diff};
        prod   = diff_w * $signed({1'b0, softmax_pkg::log2e_q});

        // Arithmetic shift truncates toward minus infinity.
        if (scale_log2e) begin
            scaled = prod >>> softmax_pkg::frac_w;
        end else begin
            scaled = diff_w;
        end

        // Clamp to [min_exp, 0].
        if (!scaled[2*softmax_pkg::data_w+1]) begin
            clamped.raw = '0;
        end else if (scaled < softmax_pkg::min_exp) begin
            clamped.raw = softmax_pkg::min_exp;
        end else begin
            clamped.raw = scaled[softmax_pkg::data_w-1:0];
        end
    end

    // Mantissa 1 + f/256 in Q1.15, shifted down by the integer magnitude.
    always_comb begin
        mant = {1'b1, expo_q.split.fpart,
                {(softmax_pkg::prob_frac_w-softmax_pkg::frac_w){1'b0}}};
        shamt = -expo_q.split.ipart;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            expo_q.raw <= '0;
            valid_q    <= 1'b0;
            expo       <= '0;
            pow        <= '0;
            valid_out  <= 1'b0;
        end else if (en) begin
            expo_q    <= clamped;
            valid_q   <= valid_in;
            expo      <= expo_q.raw;
            pow       <= mant >> shamt;
            valid_out <= valid_q;
        end
    end

endmodule

`default_nettype wire

/* verilog/log_sum_tree.sv */
`default_nettype none

module log_sum_tree (
    input  wire                                                 clk,
    input  wire                                                 rst_n,
    input  wire                                                 en,
    input  wire                                                 valid_in,
    input  wire  [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] pow_flat,
    input  wire  [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] expo_flat,
    output logic [softmax_pkg::data_w-1:0]                      log_sum,
    output logic [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] expo_prop_flat,
    output logic                                                sum_valid
);

    // Same heap layout as the max tree, one register per adder.
    logic [softmax_pkg::sum_w-1:0] node      [softmax_pkg::vec_len-1];
    logic [softmax_pkg::sum_w-1:0] all_nodes [2*softmax_pkg::vec_len-1];

    // Exponents travel through the adder levels and the log stage.
    logic [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] expo_pipe [softmax_pkg::sum_lat];
    logic [softmax_pkg::sum_lat-1:0]                     valid_pipe;

    // Leading-one detector and normalizer.
    int                            lead;
    int                            lead_rel;
    logic [softmax_pkg::sum_w-1:0] norm;
    softmax_pkg::log_word_u        log_word;

    always_comb begin
        for (int i = 0; i < softmax_pkg::vec_len - 1; i++) begin
            all_nodes[i] = node[i];
        end
        for (int i = 0; i < softmax_pkg::vec_len; i++) begin
            all_nodes[softmax_pkg::vec_len-1+i] =
                {{softmax_pkg::tree_depth{1'b0}},
                 pow_flat[i*softmax_pkg::data_w +: softmax_pkg::data_w]};
        end
    end

    // Position p of the top one gives the integer part p - 15.
    // The eight bits under it become the fraction.
    always_comb begin
        lead = 0;
        for (int b = 0; b < softmax_pkg::sum_w; b++) begin
            if (node[0][b]) begin
                lead = b;
            end
        end
        lead_rel = lead - softmax_pkg::prob_frac_w;
        norm     = node[0] << (softmax_pkg::sum_w - 1 - lead);
        log_word.split.ipart = lead_rel[softmax_pkg::data_w-softmax_pkg::frac_w-1:0];
        log_word.split.fpart = norm[softmax_pkg::sum_w-2 -: softmax_pkg::frac_w];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < softmax_pkg::vec_len - 1; i++) begin
                node[i] <= '0;
            end
            for (int s = 0; s < softmax_pkg::sum_lat; s++) begin
                expo_pipe[s] <= '0;
            end
            valid_pipe <= '0;
            log_sum    <= '0;
        end else if (en) begin
            for (int i = 0; i < softmax_pkg::vec_len - 1; i++) begin
                node[i] <= all_nodes[2*i+1] + all_nodes[2*i+2];
            end
            expo_pipe[0] <= expo_flat;
            for (int s = 1; s < softmax_pkg::sum_lat; s++) begin
                expo_pipe[s] <= expo_pipe[s-1];
            end
            valid_pipe <= {valid_pipe[softmax_pkg::sum_lat-2:0], valid_in};
            log_sum    <= log_word.raw;
        end
    end

    assign expo_prop_flat = expo_pipe[softmax_pkg::sum_lat-1];
    assign sum_valid      = valid_pipe[softmax_pkg::sum_lat-1];

endmodule

`default_nettype wire

/* verilog/max_tree.sv */
`default_nettype none

module max_tree (
    input  wire                                                 clk,
    input  wire                                                 rst_n,
    input  wire                                                 en,
    input  wire                                                 valid_in,
    input  wire  [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] scores_flat,
    output logic [softmax_pkg::data_w-1:0]                      max_val,
    output logic [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] scores_prop_flat,
    output logic                                                max_valid
);

    // Heap layout: node i has children 2i+1 and 2i+2.
    // Indices below vec_len-1 are registered comparators, the rest are the scores.
    logic signed [softmax_pkg::data_w-1:0] node      [softmax_pkg::vec_len-1];
    logic signed [softmax_pkg::data_w-1:0] all_nodes [2*softmax_pkg::vec_len-1];

    // Scores ride along so they leave with their maximum.
    logic [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] score_pipe [softmax_pkg::max_lat];
    logic [softmax_pkg::max_lat-1:0]                     valid_pipe;

    always_comb begin
        for (int i = 0; i < softmax_pkg::vec_len - 1; i++) begin
            all_nodes[i] = node[i];
        end
        for (int i = 0; i < softmax_pkg::vec_len; i++) begin
            all_nodes[softmax_pkg::vec_len-1+i] =
                scores_flat[i*softmax_pkg::data_w +: softmax_pkg::data_w];
        end
    end

    // Every internal node is one register, so each tree level costs one cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < softmax_pkg::vec_len - 1; i++) begin
                node[i] <= '0;
            end
            for (int s = 0; s < softmax_pkg::max_lat; s++) begin
                score_pipe[s] <= '0;
            end
            valid_pipe <= '0;
        end else if (en) begin
            for (int i = 0; i < softmax_pkg::vec_len - 1; i++) begin
                if (all_nodes[2*i+1] >= all_nodes[2*i+2]) begin
                    node[i] <= all_nodes[2*i+1];
                end else begin
                    node[i] <= all_nodes[2*i+2];
                end
            end
            score_pipe[0] <= scores_flat;
            for (int s = 1; s < softmax_pkg::max_lat; s++) begin
                score_pipe[s] <= score_pipe[s-1];
            end
            valid_pipe <= {valid_pipe[softmax_pkg::max_lat-2:0], valid_in};
        end
    end

    assign max_val          = node[0];
    assign scores_prop_flat = score_pipe[softmax_pkg::max_lat-1];
    assign max_valid        = valid_pipe[softmax_pkg::max_lat-1];

endmodule

`default_nettype wire

/* verilog/softmax.sv */
`default_nettype none

module softmax (
    input  wire                                                 clk,
    input  wire                                                 rst_n,
    input  wire                                                 en,
    input  wire                                                 valid_in,
    input  wire  [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] scores_flat,
    output logic [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] prob_flat,
    output logic                                                valid_out
);

    // Max tree outputs.
    logic [softmax_pkg::data_w-1:0]                      max_val;
    logic [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] scores_prop_flat;
    logic                                                max_valid;

    // First exponent bank, base-2 exponents of score minus max.
    logic [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] expo_flat;
    logic [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] pow_flat;
    logic [softmax_pkg::vec_len-1:0]                     bank1_valid;

    // Log-sum tree outputs.
    logic [softmax_pkg::data_w-1:0]                      log_sum;
    logic [softmax_pkg::vec_len*softmax_pkg::data_w-1:0] expo_prop_flat;
    logic                                                sum_valid;

    logic [softmax_pkg::vec_len-1:0]                     bank2_valid;

    max_tree i_max_tree (
        .clk              (clk),
        .rst_n            (rst_n),
        .en               (en),
        .valid_in         (valid_in),
        .scores_flat      (scores_flat),
        .max_val          (max_val),
        .scores_prop_flat (scores_prop_flat),
        .max_valid        (max_valid)
    );

    for (genvar i = 0; i < softmax_pkg::vec_len; i++) begin : g_bank1
        exp2_unit #(.scale_log2e(1'b1)) i_exp (
            .clk        (clk),
            .rst_n      (rst_n),
            .en         (en),
            .valid_in   (max_valid),
            .minuend    (scores_prop_flat[i*softmax_pkg::data_w +: softmax_pkg::data_w]),
            .subtrahend (max_val),
            .expo       (expo_flat[i*softmax_pkg::data_w +: softmax_pkg::data_w]),
            .pow        (pow_flat[i*softmax_pkg::data_w +: softmax_pkg::data_w]),
            .valid_out  (bank1_valid[i])
        );
    end

    log_sum_tree i_log_sum_tree (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .valid_in       (&bank1_valid),
        .pow_flat       (pow_flat),
        .expo_flat      (expo_flat),
        .log_sum        (log_sum),
        .expo_prop_flat (expo_prop_flat),
        .sum_valid      (sum_valid)
    );

    // Second bank divides by the sum in the log domain. No log2(e) scaling here.
    for (genvar i = 0; i < softmax_pkg::vec_len; i++) begin : g_bank2
        exp2_unit #(.scale_log2e(1'b0)) i_exp (
            .clk        (clk),
            .rst_n      (rst_n),
            .en         (en),
            .valid_in   (sum_valid),
            .minuend    (expo_prop_flat[i*softmax_pkg::data_w +: softmax_pkg::data_w]),
            .subtrahend (log_sum),
            .expo       (),
            .pow        (prob_flat[i*softmax_pkg::data_w +: softmax_pkg::data_w]),
            .valid_out  (bank2_valid[i])
        );
    end

    assign valid_out = &bank2_valid;

endmodule

`default_nettype wire

/* verilog/softmax_pkg.sv */
`default_nettype none

package softmax_pkg;

    // Vector shape.
    localparam int vec_len    = 8;
    localparam int tree_depth = 3;

    // Scores and probabilities share one word width.
    localparam int data_w = 16;

    // Log-domain words are signed Q8.8.
    localparam int frac_w = 8;

    // Exponent results are unsigned Q1.15, so 1.0 is 0x8000.
    localparam int prob_frac_w = 15;

    // Eight Q1.15 terms need three extra bits.
    localparam int sum_w = data_w + tree_depth;

    // log2(e) in Q8.8.
    localparam logic [data_w-1:0] log2e_q = 16'h0171;

    // Floor of the log domain, -16.0 in Q8.8.
    localparam logic signed [data_w-1:0] min_exp = -16 * (1 << frac_w);

    // Stage latencies, counted in enabled cycles.
    localparam int exp_lat   = 2;
    localparam int max_lat   = tree_depth;
    localparam int sum_lat   = tree_depth + 1;
    localparam int total_lat = max_lat + exp_lat + sum_lat + exp_lat;

    // One log-domain word.
    // Read whole as a signed Q8.8 value, or split into its integer part
    // and its fraction. With floor rounding the fraction is never negative.
    typedef union packed {
        logic signed [data_w-1:0] raw;
        struct packed {
            logic signed [data_w-frac_w-1:0] ipart;
            logic        [frac_w-1:0]        fpart;
        } split;
    } log_word_u;

endpackage

`default_nettype wire
